/* common/exe_pkg.sv */
package exe_pkg;

    // ========================================================================
    // widths and basic types
    // ========================================================================

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      funct3_t;

    // pc increment for the link address
    localparam word_t PC_STEP = 32'd4;

    // ========================================================================
    // alu operations
    // ========================================================================

    // encoded as {funct7[5], funct3} of the matching R-type instruction
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_op_e;

    // branch conditions, funct3 of the B-type instructions
    localparam funct3_t BEQ  = 3'b000;
    localparam funct3_t BNE  = 3'b001;
    localparam funct3_t BLT  = 3'b100;
    localparam funct3_t BGE  = 3'b101;
    localparam funct3_t BLTU = 3'b110;
    localparam funct3_t BGEU = 3'b111;

    // ========================================================================
    // bubble contents
    // ========================================================================

    // data value loaded into a stage on clear or reset
    localparam word_t BUBBLE_WORD = '0;

    // alu operation carried by a bubble
    localparam alu_op_e BUBBLE_ALU_OP = ADD;

endpackage

/* hdl/id_exe_reg.sv */
`timescale 1ns/10ps

module id_exe_reg (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              en_i,
    input  logic              clr_i,
    input  exe_pkg::word_t    pc_i,
    input  exe_pkg::word_t    imm_i,
    input  exe_pkg::word_t    rdata1_i,
    input  exe_pkg::word_t    rdata2_i,
    input  exe_pkg::reg_addr_t rd_i,
    input  exe_pkg::funct3_t  fun3_i,
    input  exe_pkg::alu_op_e  alu_ctrl_i,
    input  logic              reg_write_i,
    input  logic              mem_write_i,
    input  logic              mem_to_reg_i,
    input  logic              branch_i,
    input  logic              alu_src_i,
    input  logic              jump_i,
    input  logic              lui_i,
    input  logic              auipc_i,
    input  logic              jal_i,
    output exe_pkg::word_t    pc_o,
    output exe_pkg::word_t    imm_o,
    output exe_pkg::word_t    rdata1_o,
    output exe_pkg::word_t    rdata2_o,
    output exe_pkg::reg_addr_t rd_o,
    output exe_pkg::funct3_t  fun3_o,
    output exe_pkg::alu_op_e  alu_ctrl_o,
    output logic              reg_write_o,
    output logic              mem_write_o,
    output logic              mem_to_reg_o,
    output logic              branch_o,
    output logic              alu_src_o,
    output logic              jump_o,
    output logic              lui_o,
    output logic              auipc_o,
    output logic              jal_o
);

    // reset and clear both insert a bubble, clear wins over enable
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clr_i) begin
            pc_o         <= exe_pkg::BUBBLE_WORD;
            imm_o        <= exe_pkg::BUBBLE_WORD;
            rdata1_o     <= exe_pkg::BUBBLE_WORD;
            rdata2_o     <= exe_pkg::BUBBLE_WORD;
            rd_o         <= '0;
            fun3_o       <= '0;
            alu_ctrl_o   <= exe_pkg::BUBBLE_ALU_OP;
            reg_write_o  <= 1'b0;
            mem_write_o  <= 1'b0;
            mem_to_reg_o <= 1'b0;
            branch_o     <= 1'b0;
            alu_src_o    <= 1'b0;
            jump_o       <= 1'b0;
            lui_o        <= 1'b0;
            auipc_o      <= 1'b0;
            jal_o        <= 1'b0;
        end else if (en_i) begin
            pc_o         <= pc_i;
            imm_o        <= imm_i;
            rdata1_o     <= rdata1_i;
            rdata2_o     <= rdata2_i;
            rd_o         <= rd_i;
            fun3_o       <= fun3_i;
            alu_ctrl_o   <= alu_ctrl_i;
            reg_write_o  <= reg_write_i;
            mem_write_o  <= mem_write_i;
            mem_to_reg_o <= mem_to_reg_i;
            branch_o     <= branch_i;
            alu_src_o    <= alu_src_i;
            jump_o       <= jump_i;
            lui_o        <= lui_i;
            auipc_o      <= auipc_i;
            jal_o        <= jal_i;
        end
    end

    // a cleared stage carries no side effects into execute
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        clr_i |=> !(reg_write_o | mem_write_o | mem_to_reg_o | branch_o | alu_src_o |
                    jump_o | lui_o | auipc_o | jal_o))
        else $error("id_exe_reg: control bits set after clear");

endmodule

/* alu/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit (
    input  exe_pkg::word_t   rdata1_i,
    input  exe_pkg::word_t   rdata2_i,
    input  exe_pkg::word_t   pc_i,
    input  exe_pkg::word_t   imm_i,
    input  logic             auipc_i,
    input  logic             alu_src_i,
    input  exe_pkg::alu_op_e alu_ctrl_i,
    output exe_pkg::word_t   alu_result_o,
    output logic             zero_o
);

    exe_pkg::word_t op1;
    exe_pkg::word_t op2;
    logic [4:0]     shamt;
    logic           lt_signed;
    logic           lt_unsigned;

    // ========================================================================
    // operand selection
    // ========================================================================

    // auipc adds the immediate to the pc
    assign op1 = auipc_i ? pc_i : rdata1_i;
    assign op2 = alu_src_i ? imm_i : rdata2_i;

    // only the low five bits count for rv32 shifts
    assign shamt = op2[4:0];

    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    // ========================================================================
    // alu
    // ========================================================================

    always_comb begin
        case (alu_ctrl_i)
            exe_pkg::ADD:  alu_result_o = op1 + op2;
            exe_pkg::SUB:  alu_result_o = op1 - op2;
            exe_pkg::SLL:  alu_result_o = op1 << shamt;
            exe_pkg::SLT:  alu_result_o = {{(exe_pkg::XLEN-1){1'b0}}, lt_signed};
            exe_pkg::SLTU: alu_result_o = {{(exe_pkg::XLEN-1){1'b0}}, lt_unsigned};
            exe_pkg::XOR:  alu_result_o = op1 ^ op2;
            exe_pkg::SRL:  alu_result_o = op1 >> shamt;
            exe_pkg::SRA:  alu_result_o = exe_pkg::word_t'($signed(op1) >>> shamt);
            exe_pkg::OR:   alu_result_o = op1 | op2;
            exe_pkg::AND:  alu_result_o = op1 & op2;
            default:       alu_result_o = '0;
        endcase

        // zero flag feeds the beq/bne decision in the memory stage
        zero_o = (alu_result_o == '0);

        // a subtraction reports zero exactly when the operands match
        if (alu_ctrl_i == exe_pkg::SUB) begin
            assert (zero_o == (op1 == op2))
                else $error("alu_unit: zero flag disagrees with operand compare");
        end
    end

endmodule

/* hdl/jump_target.sv */
`timescale 1ns/10ps

module jump_target (
    input  exe_pkg::word_t pc_i,
    input  exe_pkg::word_t rdata1_i,
    input  exe_pkg::word_t imm_i,
    input  logic           jump_i,
    input  logic           jal_i,
    output exe_pkg::word_t pc_jump_o
);

    logic           jalr;
    exe_pkg::word_t base;

    // jalr is a jump that is not jal
    assign jalr = jump_i & ~jal_i;

    // jalr targets rs1 + imm, jal and branches target pc + imm
    assign base = jalr ? rdata1_i : pc_i;

    // wraps modulo 2^32
    assign pc_jump_o = base + imm_i;

endmodule

/* hdl/exe_mem_stage.sv */
`timescale 1ns/10ps

module exe_mem_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               en_i,
    input  logic               clr_i,
    input  exe_pkg::word_t     alu_result_i,
    input  logic               zero_i,
    input  exe_pkg::word_t     pc_jump_i,
    input  exe_pkg::word_t     pc_plus_4_i,
    input  exe_pkg::word_t     imm_i,
    input  exe_pkg::word_t     rdata2_i,
    input  exe_pkg::reg_addr_t rd_i,
    input  exe_pkg::funct3_t   fun3_i,
    input  logic               reg_write_i,
    input  logic               mem_write_i,
    input  logic               mem_to_reg_i,
    input  logic               branch_i,
    input  logic               jump_i,
    input  logic               lui_i,
    output exe_pkg::word_t     result_o,
    output exe_pkg::word_t     mem_addr_o,
    output exe_pkg::word_t     mem_wdata_o,
    output exe_pkg::funct3_t   mem_op_o,
    output logic               mem_write_o,
    output logic               mem_to_reg_o,
    output logic               reg_write_o,
    output exe_pkg::reg_addr_t rd_o,
    output logic               pc_sel_o,
    output exe_pkg::word_t     pc_jump_o
);

    exe_pkg::word_t   alu_result_mem;
    exe_pkg::word_t   pc_plus_4_mem;
    exe_pkg::word_t   imm_mem;
    exe_pkg::funct3_t fun3_mem;
    logic             zero_mem;
    logic             branch_mem;
    logic             jump_mem;
    logic             lui_mem;
    logic             cond_met;

    // ========================================================================
    // exe/mem register
    // ========================================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clr_i) begin
            alu_result_mem <= exe_pkg::BUBBLE_WORD;
            zero_mem       <= 1'b0;
            pc_jump_o      <= exe_pkg::BUBBLE_WORD;
            pc_plus_4_mem  <= exe_pkg::BUBBLE_WORD;
            imm_mem        <= exe_pkg::BUBBLE_WORD;
            mem_wdata_o    <= exe_pkg::BUBBLE_WORD;
            rd_o           <= '0;
            fun3_mem       <= '0;
            reg_write_o    <= 1'b0;
            mem_write_o    <= 1'b0;
            mem_to_reg_o   <= 1'b0;
            branch_mem     <= 1'b0;
            jump_mem       <= 1'b0;
            lui_mem        <= 1'b0;
        end else if (en_i) begin
            alu_result_mem <= alu_result_i;
            zero_mem       <= zero_i;
            pc_jump_o      <= pc_jump_i;
            pc_plus_4_mem  <= pc_plus_4_i;
            imm_mem        <= imm_i;
            mem_wdata_o    <= rdata2_i;
            rd_o           <= rd_i;
            fun3_mem       <= fun3_i;
            reg_write_o    <= reg_write_i;
            mem_write_o    <= mem_write_i;
            mem_to_reg_o   <= mem_to_reg_i;
            branch_mem     <= branch_i;
            jump_mem       <= jump_i;
            lui_mem        <= lui_i;
        end
    end

    // ========================================================================
    // branch decision and result select
    // ========================================================================

    // blt/bge use the slt result, beq/bne use the sub zero flag
    always_comb begin
        case (fun3_mem)
            exe_pkg::BEQ:  cond_met = zero_mem;
            exe_pkg::BNE:  cond_met = ~zero_mem;
            exe_pkg::BLT,
            exe_pkg::BLTU: cond_met = alu_result_mem[0];
            exe_pkg::BGE,
            exe_pkg::BGEU: cond_met = ~alu_result_mem[0];
            default:       cond_met = 1'b0;
        endcase
    end

    assign pc_sel_o = jump_mem | (branch_mem & cond_met);

    assign result_o = jump_mem ? pc_plus_4_mem :
                      lui_mem  ? imm_mem       : alu_result_mem;

    // data memory bus
    assign mem_addr_o = alu_result_mem;
    assign mem_op_o   = fun3_mem;

    // decode never marks one instruction as both jump and lui
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(jump_mem && lui_mem))
        else $error("exe_mem_stage: jump and lui both set");

endmodule

/* hdl/exe_mem_path.sv */
`timescale 1ns/10ps

module exe_mem_path (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // decode-stage values
    input  exe_pkg::word_t     pc_i,
    input  exe_pkg::word_t     imm_i,
    input  exe_pkg::word_t     rdata1_i,
    input  exe_pkg::word_t     rdata2_i,
    input  exe_pkg::reg_addr_t rd_i,
    input  exe_pkg::funct3_t   fun3_i,
    input  logic               reg_write_i,
    input  logic               mem_write_i,
    input  logic               mem_to_reg_i,
    input  logic               branch_i,
    input  logic               alu_src_i,
    input  logic               jump_i,
    input  logic               lui_i,
    input  logic               auipc_i,
    input  logic               jal_i,
    input  exe_pkg::alu_op_e   alu_ctrl_i,
    // pipeline flow
    input  logic               id_exe_en_i,
    input  logic               id_exe_clr_i,
    input  logic               exe_mem_en_i,
    input  logic               exe_mem_clr_i,
    // memory stage
    output exe_pkg::word_t     result_o,
    output exe_pkg::word_t     mem_addr_o,
    output exe_pkg::word_t     mem_wdata_o,
    output exe_pkg::funct3_t   mem_op_o,
    output logic               mem_write_o,
    output logic               mem_to_reg_o,
    output logic               reg_write_o,
    output exe_pkg::reg_addr_t rd_o,
    output logic               pc_sel_o,
    output exe_pkg::word_t     pc_jump_o
);

    exe_pkg::word_t     pc_exe, imm_exe, rdata1_exe, rdata2_exe;
    exe_pkg::word_t     pc_plus_4_exe, alu_result_exe, pc_jump_exe;
    exe_pkg::reg_addr_t rd_exe;
    exe_pkg::funct3_t   fun3_exe;
    exe_pkg::alu_op_e   alu_ctrl_exe;
    logic               reg_write_exe, mem_write_exe, mem_to_reg_exe, branch_exe;
    logic               alu_src_exe, jump_exe, lui_exe, auipc_exe, jal_exe;
    logic               zero_exe;

    id_exe_reg u_id_exe_reg (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(id_exe_en_i), .clr_i(id_exe_clr_i),
        .pc_i(pc_i), .imm_i(imm_i), .rdata1_i(rdata1_i), .rdata2_i(rdata2_i),
        .rd_i(rd_i), .fun3_i(fun3_i), .alu_ctrl_i(alu_ctrl_i),
        .reg_write_i(reg_write_i), .mem_write_i(mem_write_i), .mem_to_reg_i(mem_to_reg_i),
        .branch_i(branch_i), .alu_src_i(alu_src_i), .jump_i(jump_i), .lui_i(lui_i),
        .auipc_i(auipc_i), .jal_i(jal_i),
        .pc_o(pc_exe), .imm_o(imm_exe), .rdata1_o(rdata1_exe), .rdata2_o(rdata2_exe),
        .rd_o(rd_exe), .fun3_o(fun3_exe), .alu_ctrl_o(alu_ctrl_exe),
        .reg_write_o(reg_write_exe), .mem_write_o(mem_write_exe),
        .mem_to_reg_o(mem_to_reg_exe), .branch_o(branch_exe), .alu_src_o(alu_src_exe),
        .jump_o(jump_exe), .lui_o(lui_exe), .auipc_o(auipc_exe), .jal_o(jal_exe)
    );

    // link address for jal/jalr
    assign pc_plus_4_exe = pc_exe + exe_pkg::PC_STEP;

    alu_unit u_alu_unit (
        .rdata1_i(rdata1_exe), .rdata2_i(rdata2_exe), .pc_i(pc_exe), .imm_i(imm_exe),
        .auipc_i(auipc_exe), .alu_src_i(alu_src_exe), .alu_ctrl_i(alu_ctrl_exe),
        .alu_result_o(alu_result_exe), .zero_o(zero_exe)
    );

    jump_target u_jump_target (
        .pc_i(pc_exe), .rdata1_i(rdata1_exe), .imm_i(imm_exe),
        .jump_i(jump_exe), .jal_i(jal_exe), .pc_jump_o(pc_jump_exe)
    );

    exe_mem_stage u_exe_mem_stage (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .en_i(exe_mem_en_i), .clr_i(exe_mem_clr_i),
        .alu_result_i(alu_result_exe), .zero_i(zero_exe), .pc_jump_i(pc_jump_exe),
        .pc_plus_4_i(pc_plus_4_exe), .imm_i(imm_exe), .rdata2_i(rdata2_exe),
        .rd_i(rd_exe), .fun3_i(fun3_exe), .reg_write_i(reg_write_exe),
        .mem_write_i(mem_write_exe), .mem_to_reg_i(mem_to_reg_exe),
        .branch_i(branch_exe), .jump_i(jump_exe), .lui_i(lui_exe),
        .result_o(result_o), .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
        .mem_op_o(mem_op_o), .mem_write_o(mem_write_o), .mem_to_reg_o(mem_to_reg_o),
        .reg_write_o(reg_write_o), .rd_o(rd_o), .pc_sel_o(pc_sel_o),
        .pc_jump_o(pc_jump_o)
    );

endmodule

/* tests/exe_mem_path_tb.sv */
`timescale 1ns/10ps

module exe_mem_path_tb;

    localparam int MAX_VEC = 64;

    logic clk_i, rst_n_i;
    exe_pkg::word_t pc_i, imm_i, rdata1_i, rdata2_i;
    exe_pkg::reg_addr_t rd_i;
    exe_pkg::funct3_t fun3_i;
    logic reg_write_i, mem_write_i, mem_to_reg_i, branch_i, alu_src_i;
    logic jump_i, lui_i, auipc_i, jal_i;
    exe_pkg::alu_op_e alu_ctrl_i;
    logic id_exe_en_i, id_exe_clr_i, exe_mem_en_i, exe_mem_clr_i;
    exe_pkg::word_t result_o, mem_addr_o, mem_wdata_o, pc_jump_o;
    exe_pkg::funct3_t mem_op_o;
    logic mem_write_o, mem_to_reg_o, reg_write_o, pc_sel_o;
    exe_pkg::reg_addr_t rd_o;

    // one vector table entry per data line
    logic [31:0] code_v[MAX_VEC], dc_v[MAX_VEC], op_v[MAX_VEC], fun3_v[MAX_VEC];
    logic [31:0] ctrl_v[MAX_VEC], pc_v[MAX_VEC], imm_v[MAX_VEC], rs1_v[MAX_VEC];
    logic [31:0] rs2_v[MAX_VEC], rd_v[MAX_VEC], res_v[MAX_VEC], sel_v[MAX_VEC];
    logic [31:0] jmp_v[MAX_VEC], wdata_v[MAX_VEC], strb_v[MAX_VEC];
    int num_vec;
    int error_count;

    // shadow of the two stages where -1 marks a bubble
    int slot_exe, slot_mem;
    int cur_in;
    logic cur_en, cur_clr, cur_mclr;

    exe_mem_path uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        fd = $fopen("tests/exe_mem_path_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file");
            $display("TESTS FAILED");
            $fatal(1, "no vectors");
        end
        num_vec = 0;
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 2 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    code_v[num_vec], dc_v[num_vec], op_v[num_vec], fun3_v[num_vec],
                    ctrl_v[num_vec], pc_v[num_vec], imm_v[num_vec], rs1_v[num_vec],
                    rs2_v[num_vec], rd_v[num_vec], res_v[num_vec], sel_v[num_vec],
                    jmp_v[num_vec], wdata_v[num_vec], strb_v[num_vec]);
                if (n == 15)
                    num_vec++;
            end
        end
        $fclose(fd);
    endtask

    // advance the shadow stages with the levels the DUT saw at this edge
    task automatic step_edge();
        @(posedge clk_i);
        if (cur_mclr)
            slot_mem = -1;
        else if (cur_en)
            slot_mem = slot_exe;
        if (cur_clr)
            slot_exe = -1;
        else if (cur_en)
            slot_exe = cur_in;
    endtask

    task automatic drive_vector(input int i);
        logic [31:0] c;
        c = ctrl_v[i];
        pc_i         <= pc_v[i];
        imm_i        <= imm_v[i];
        rdata1_i     <= dc_v[i][0] ? $urandom : rs1_v[i];
        rdata2_i     <= dc_v[i][1] ? $urandom : rs2_v[i];
        rd_i         <= rd_v[i][4:0];
        fun3_i       <= fun3_v[i][2:0];
        alu_ctrl_i   <= exe_pkg::alu_op_e'(op_v[i][3:0]);
        {reg_write_i, mem_write_i, mem_to_reg_i, branch_i, alu_src_i} <= c[8:4];
        {jump_i, lui_i, auipc_i, jal_i} <= c[3:0];
        id_exe_clr_i <= (code_v[i] == 1);
        id_exe_en_i  <= 1'b1;
        exe_mem_en_i <= 1'b1;
        cur_in  = i;
        cur_en  = 1'b1;
        cur_clr = (code_v[i] == 1);
    endtask

    // checks the memory stage against the entry that the shadow says is there
    task automatic check_mem_stage();
        int i;
        logic [31:0] strobes;
        @(negedge clk_i);
        i = slot_mem;
        strobes = {29'd0, reg_write_o, mem_write_o, mem_to_reg_o};
        if (i < 0) begin
            compare("bubble result_o", result_o, 32'd0);
            compare("bubble pc_sel_o", {31'd0, pc_sel_o}, 32'd0);
            compare("bubble pc_jump_o", pc_jump_o, 32'd0);
            compare("bubble mem_addr_o", mem_addr_o, 32'd0);
            compare("bubble mem_wdata_o", mem_wdata_o, 32'd0);
            compare("bubble mem_op_o", {29'd0, mem_op_o}, 32'd0);
            compare("bubble rd_o", {27'd0, rd_o}, 32'd0);
            compare("bubble strobes", strobes, 32'd0);
        end else begin
            compare("result_o", result_o, res_v[i]);
            compare("pc_sel_o", {31'd0, pc_sel_o}, sel_v[i]);
            compare("pc_jump_o", pc_jump_o, jmp_v[i]);
            compare("strobes", strobes, strb_v[i]);
            compare("rd_o", {27'd0, rd_o}, rd_v[i]);
            compare("mem_op_o", {29'd0, mem_op_o}, fun3_v[i]);
            if (!ctrl_v[i][3] && !ctrl_v[i][2])
                compare("mem_addr_o", mem_addr_o, res_v[i]);
            if (!dc_v[i][1])
                compare("mem_wdata_o", mem_wdata_o, wdata_v[i]);
        end
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(32'hd42b_d2fc));
        error_count = 0;
        rst_n_i = 1'b0;
        {pc_i, imm_i, rdata1_i, rdata2_i} = '0;
        rd_i = '0;
        fun3_i = '0;
        {reg_write_i, mem_write_i, mem_to_reg_i, branch_i, alu_src_i} = '0;
        {jump_i, lui_i, auipc_i, jal_i} = '0;
        alu_ctrl_i = exe_pkg::ADD;
        {id_exe_en_i, exe_mem_en_i} = 2'b11;
        {id_exe_clr_i, exe_mem_clr_i} = 2'b00;
        slot_exe = -1;
        slot_mem = -1;
        cur_in = -1;
        cur_en = 1'b1;
        cur_clr = 1'b0;
        cur_mclr = 1'b0;
        load_vectors();

        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // strobes must settle low once reset is gone
        wait_cycles = 0;
        while (reg_write_o !== 1'b0 || mem_write_o !== 1'b0 || mem_to_reg_o !== 1'b0 ||
               pc_sel_o !== 1'b0) begin
            @(negedge clk_i);
            wait_cycles++;
            if (wait_cycles > 20) begin
                $display("strobes did not come out of reset low in time");
                $display("TESTS FAILED");
                $fatal(1, "reset timeout");
            end
        end
        check_mem_stage();

        // ====================================================================
        // vector stream
        // ====================================================================
        for (int i = 0; i < num_vec; i++) begin
            if (code_v[i] == 2) begin
                // freeze both stages with the next vector already on the inputs
                for (int s = 0; s < 3; s++) begin
                    step_edge();
                    drive_vector(i);
                    id_exe_en_i  <= 1'b0;
                    exe_mem_en_i <= 1'b0;
                    cur_en = 1'b0;
                    check_mem_stage();
                end
            end
            step_edge();
            drive_vector(i);
            check_mem_stage();
        end

        // replay the first vector and drop it in the memory stage
        step_edge();
        drive_vector(0);
        check_mem_stage();
        step_edge();
        id_exe_clr_i  <= 1'b1;
        exe_mem_clr_i <= 1'b1;
        cur_clr  = 1'b1;
        cur_mclr = 1'b1;
        check_mem_stage();
        for (int d = 0; d < 2; d++) begin
            step_edge();
            check_mem_stage();
        end

        if (error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* exe_mem_path.f */
common/exe_pkg.sv
hdl/id_exe_reg.sv
alu/alu_unit.sv
hdl/jump_target.sv
hdl/exe_mem_stage.sv
hdl/exe_mem_path.sv
tests/exe_mem_path_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the execute/memory path testbench with Verilator and runs it
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module exe_mem_path_tb -f exe_mem_path.f \
    || { echo "build failed"; exit 1; }
./obj_dir/Vexe_mem_path_tb > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/exe_mem_path_tests.txt */
# code(0 run,1 clear,2 stall first) dc(b0 rs1,b1 rs2) op fun3 ctrl pc imm rs1 rs2 rd
# then expected: result pc_sel pc_jump wdata strobes{reg_write,mem_write,mem_to_reg}
0 0 0 0 100 00000100 00000000 00000005 00000007 01 0000000c 0 00000100 00000007 4
0 0 8 0 100 00000104 00000000 00000003 00000005 02 fffffffe 0 00000104 00000005 4
0 2 1 1 110 00000108 00000024 0000000f 00000000 03 000000f0 0 0000012c 00000000 4
0 0 2 2 100 0000010c 00000000 ffffffff 00000001 04 00000001 0 0000010c 00000001 4
0 0 3 3 100 00000110 00000000 ffffffff 00000001 05 00000000 0 00000110 00000001 4
0 2 4 4 110 00000114 0000ff00 0f0f0f0f 00000000 06 0f0ff00f 0 00010014 00000000 4
0 0 5 5 100 00000118 00000000 80000000 00000021 07 40000000 0 00000118 00000021 4
0 2 d 5 110 0000011c 00000404 80000000 00000000 08 f8000000 0 00000520 00000000 4
0 0 6 6 100 00000120 00000000 12340000 00005678 09 12345678 0 00000120 00005678 4
0 2 7 7 110 00000124 fffffff0 abcdef17 00000000 0a abcdef10 0 00000114 00000000 4
0 2 0 0 110 00000128 fffffffc 00000010 00000000 0b 0000000c 0 00000124 00000000 4
0 3 0 0 112 0000012c 12345000 00000000 00000000 0c 1234512c 0 1234512c 00000000 4
0 0 8 0 020 00000200 00000010 00000005 00000005 00 00000000 1 00000210 00000005 0
0 0 8 0 020 00000204 fffffff0 00000005 00000006 00 ffffffff 0 000001f4 00000006 0
0 0 8 1 020 00000208 00000020 00000009 00000004 00 00000005 1 00000228 00000004 0
0 0 8 1 020 0000020c 00000020 00000007 00000007 00 00000000 0 0000022c 00000007 0
0 0 2 4 020 00000210 00000040 fffffffe 00000003 00 00000001 1 00000250 00000003 0
0 0 2 4 020 00000214 00000040 00000003 fffffffe 00 00000000 0 00000254 fffffffe 0
0 0 2 5 020 00000218 ffffff00 00000003 fffffffe 00 00000000 1 00000118 fffffffe 0
0 0 2 5 020 0000021c 00000008 fffffffe 00000003 00 00000001 0 00000224 00000003 0
0 0 3 6 020 00000220 00000010 00000003 fffffffe 00 00000001 1 00000230 fffffffe 0
0 0 3 6 020 00000224 00000010 fffffffe 00000003 00 00000000 0 00000234 00000003 0
0 0 3 7 020 00000228 00000010 fffffffe 00000003 00 00000000 1 00000238 00000003 0
0 0 3 7 020 0000022c 00000010 00000003 fffffffe 00 00000001 0 0000023c fffffffe 0
0 3 0 0 109 00000300 00000100 00000000 00000000 01 00000304 1 00000400 00000000 4
0 2 0 0 118 00000304 00000008 00001000 00000000 01 00000308 1 00001008 00000000 4
0 3 0 0 114 00000308 abcde000 00000000 00000000 02 abcde000 0 abcde308 00000000 4
2 0 0 2 090 0000030c 00000010 00002000 cafef00d 00 00002010 0 0000031c cafef00d 2
1 0 0 2 150 00000310 00000004 00003000 00000000 05 00000000 0 00000000 00000000 0
0 2 0 2 150 00000314 fffffffc 00003000 00000000 06 00002ffc 0 00000310 00000000 5
0 0 0 0 090 00000318 00000001 00004000 000000ab 00 00004001 0 00000319 000000ab 2
